//--- rename_pkg.sv
/*
  shared definitions for the single-wide rename / dispatch front
  sizes here are defaults only, rename_top parameters override them
  inst_t overlays the r-type and s-type field layouts on one rv32 word
  physical and rob index widths are derived inside each module
*/
`default_nettype none

package rename_pkg;

    // ==================================================
    // default sizes
    // ==================================================
    localparam int ARCH_REGS = 32;   // x0..x31
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 16;

    typedef logic [4:0] arch_idx_t;

    // ==================================================
    // rv32 major opcodes
    // ==================================================
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    typedef struct packed {
        logic [6:0] funct7;   // bit 0 selects mul/div on OP_REG
        arch_idx_t  rs2;
        arch_idx_t  rs1;
        logic [2:0] funct3;
        arch_idx_t  rd;
        logic [6:0] opcode;
    } r_fields_t;

    // store / branch layout, bits 11:7 hold immediate not rd
    typedef struct packed {
        logic [6:0] imm_hi;
        arch_idx_t  rs2;
        arch_idx_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    typedef union packed {
        r_fields_t r;
        s_fields_t s;
    } inst_t;

    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MULT   = 2'd1,
        FU_MEM    = 2'd2,
        FU_BRANCH = 2'd3
    } fu_class_t;

endpackage

`default_nettype wire

//--- rename_ifs.sv
/*
  rename_if joins dispatch to the map table and free list
  alloc is a one-cycle strobe, pops the free list and writes the map
  rob_if is the rob write port plus tail index and full flag
*/
`timescale 1ns/1ps
`default_nettype none

interface rename_if #(
    parameter int PHYS_REGS = rename_pkg::PHYS_REGS
);
    import rename_pkg::*;

    arch_idx_t                      src1_arch;
    arch_idx_t                      src2_arch;
    arch_idx_t                      dest_arch;
    logic [$clog2(PHYS_REGS)-1:0]   src1_prf;
    logic [$clog2(PHYS_REGS)-1:0]   src2_prf;
    logic [$clog2(PHYS_REGS)-1:0]   old_prf;    // current mapping of dest_arch
    logic [$clog2(PHYS_REGS)-1:0]   new_prf;    // free list head
    logic [$clog2(PHYS_REGS+1)-1:0] free_count;
    logic                           alloc;

    modport disp (output src1_arch, src2_arch, dest_arch, alloc,
                  input  src1_prf, src2_prf, old_prf, new_prf, free_count);
    modport tables (input  src1_arch, src2_arch, dest_arch, alloc,
                    output src1_prf, src2_prf, old_prf, new_prf, free_count);
endinterface

interface rob_if #(
    parameter int PHYS_REGS = rename_pkg::PHYS_REGS,
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH
);
    import rename_pkg::*;

    logic                         wr;
    arch_idx_t                    arch;
    logic [$clog2(PHYS_REGS)-1:0] new_prf;
    logic [$clog2(PHYS_REGS)-1:0] old_prf;
    logic                         wen;
    logic [$clog2(ROB_DEPTH)-1:0] tail_idx;
    logic                         full;

    modport disp (output wr, arch, new_prf, old_prf, wen, input tail_idx, full);
    modport buffer (input wr, arch, new_prf, old_prf, wen, output tail_idx, full);
endinterface

`default_nettype wire

//--- inst_decoder.sv
/*
  combinational classify of one rv32 word
  unknown opcodes come out as alu with no destination
  mult is OP_REG with funct7[0] set, no other m-extension check
*/
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  rename_pkg::inst_t     inst_i,
    output rename_pkg::fu_class_t fu_o,
    output logic                  has_dest_o,
    output logic                  is_mem_o,
    output logic                  is_store_o
);
    import rename_pkg::*;

    logic split_imm;   // s/b layout, no rd field
    logic known;       // opcode in the supported set

    // the s view decides whether bits 11:7 are a register at all
    assign split_imm = (inst_i.s.opcode == OP_STORE) || (inst_i.s.opcode == OP_BRANCH);

    always_comb begin
        fu_o       = FU_ALU;   // fallback class
        known      = 1'b1;
        is_mem_o   = 1'b0;
        is_store_o = 1'b0;
        case (inst_i.r.opcode)
            OP_REG: begin
                fu_o = inst_i.r.funct7[0] ? FU_MULT : FU_ALU;
            end
            OP_IMM, OP_LUI: begin
                fu_o = FU_ALU;
            end
            OP_LOAD: begin
                fu_o     = FU_MEM;
                is_mem_o = 1'b1;
            end
            OP_STORE: begin
                fu_o       = FU_MEM;
                is_mem_o   = 1'b1;
                is_store_o = 1'b1;
            end
            OP_BRANCH, OP_JAL: begin
                fu_o = FU_BRANCH;   // jal writes the link reg
            end
            default: begin
                known = 1'b0;
            end
        endcase
        has_dest_o = known && !split_imm;
    end

endmodule

`default_nettype wire

//--- free_list.sv
/*
  circular fifo of free physical registers
  holds PHYS_REGS-ARCH_REGS entries, starts full with ARCH_REGS.. ascending
  alloc and release may share a cycle; a release is visible one cycle later
  no overflow / underflow guard, dispatch stalls on free_count == 0
*/
`timescale 1ns/1ps
`default_nettype none

module free_list #(
    parameter int PHYS_REGS = 64,
    parameter int ARCH_REGS = 32
) (
    input  logic                         clock,
    input  logic                         reset,
    rename_if.tables                     ren,
    input  logic                         release_valid_i,
    input  logic [$clog2(PHYS_REGS)-1:0] release_prf_i
);
    localparam int DEPTH = PHYS_REGS - ARCH_REGS;
    localparam int PW    = $clog2(PHYS_REGS);
    localparam int AW    = $clog2(DEPTH);
    localparam int CW    = $clog2(PHYS_REGS + 1);

    logic [PW-1:0] fifo_q [DEPTH];
    logic [AW-1:0] head_q;
    logic [AW-1:0] tail_q;
    logic [CW-1:0] count_q;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign ren.new_prf    = fifo_q[head_q];   // head is next to hand out
    assign ren.free_count = count_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            head_q  <= '0;
            tail_q  <= '0;            // full ring, tail sits on head
            count_q <= CW'(DEPTH);
            for (int i = 0; i < DEPTH; i++) begin
                fifo_q[i] <= PW'(ARCH_REGS + i);
            end
        end else begin
            if (ren.alloc) begin
                head_q <= bump(head_q);
            end
            if (release_valid_i) begin
                fifo_q[tail_q] <= release_prf_i;
                tail_q         <= bump(tail_q);
            end
            case ({ren.alloc, release_valid_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;   // none or both
            endcase
        end
    end

endmodule

`default_nettype wire

//--- map_table.sv
/*
  architectural to physical register map
  two source reads and the old-dest read are combinational
  write on alloc lands at the edge, entry 0 stays mapped to p0
*/
`timescale 1ns/1ps
`default_nettype none

module map_table #(
    parameter int PHYS_REGS = 64
) (
    input  logic     clock,
    input  logic     reset,
    rename_if.tables ren
);
    import rename_pkg::*;

    localparam int ENTRIES = 2 ** $bits(arch_idx_t);
    localparam int PW      = $clog2(PHYS_REGS);

    logic [PW-1:0] map_q [ENTRIES];

    assign ren.src1_prf = map_q[ren.src1_arch];
    assign ren.src2_prf = map_q[ren.src2_arch];
    assign ren.old_prf  = map_q[ren.dest_arch];   // recorded in rob, freed at commit

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < ENTRIES; i++) begin
                map_q[i] <= PW'(i);   // identity
            end
        end else if (ren.alloc && (ren.dest_arch != '0)) begin
            map_q[ren.dest_arch] <= ren.new_prf;
        end
    end

endmodule

`default_nettype wire

//--- reorder_buffer.sv
/*
  head/tail/count ring of dispatched entries
  commit on an empty rob is dropped; a write at full is not guarded
  commit record and release are registered, one cycle after commit_i
*/
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 16,
    parameter int PHYS_REGS = 64
) (
    input  logic                         clock,
    input  logic                         reset,
    rob_if.buffer                        rob,
    input  logic                         commit_i,
    output logic                         commit_valid_o,
    output rename_pkg::arch_idx_t        commit_arch_o,
    output logic [$clog2(PHYS_REGS)-1:0] commit_new_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] commit_old_prf_o,
    output logic                         release_valid_o,
    output logic [$clog2(PHYS_REGS)-1:0] release_prf_o
);
    import rename_pkg::*;

    localparam int PW = $clog2(PHYS_REGS);
    localparam int IW = $clog2(ROB_DEPTH);
    localparam int CW = $clog2(ROB_DEPTH + 1);

    typedef struct packed {
        arch_idx_t     arch;
        logic [PW-1:0] new_prf;
        logic [PW-1:0] old_prf;
        logic          wen;
    } entry_t;

    entry_t        ring_q [ROB_DEPTH];
    entry_t        head_entry;
    logic [IW-1:0] head_q;
    logic [IW-1:0] tail_q;
    logic [CW-1:0] count_q;
    logic          do_commit;

    function automatic logic [IW-1:0] bump(input logic [IW-1:0] ptr);
        return (ptr == IW'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_entry   = ring_q[head_q];
    assign do_commit    = commit_i && (count_q != '0);
    assign rob.tail_idx = tail_q;          // slot the next write lands in
    assign rob.full     = (count_q == CW'(ROB_DEPTH));

    // ==================================================
    // pointers, occupancy and strobes
    // ==================================================
    always_ff @(posedge clock) begin
        if (!reset) begin
            head_q          <= '0;
            tail_q          <= '0;
            count_q         <= '0;
            commit_valid_o  <= 1'b0;
            release_valid_o <= 1'b0;
        end else begin
            if (rob.wr) begin
                tail_q <= bump(tail_q);
            end
            if (do_commit) begin
                head_q <= bump(head_q);
            end
            case ({rob.wr, do_commit})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            commit_valid_o  <= do_commit;
            release_valid_o <= do_commit && head_entry.wen;   // x0 / no-dest frees nothing
        end
    end

    // entry storage and commit record
    always_ff @(posedge clock) begin
        if (rob.wr) begin
            ring_q[tail_q] <= '{arch: rob.arch, new_prf: rob.new_prf,
                                old_prf: rob.old_prf, wen: rob.wen};
        end
        if (do_commit) begin
            commit_arch_o    <= head_entry.arch;
            commit_new_prf_o <= head_entry.new_prf;
            commit_old_prf_o <= head_entry.old_prf;
            release_prf_o    <= head_entry.old_prf;
        end
    end

endmodule

`default_nettype wire

//--- dispatch_stage.sv
/*
  decode, rename and rob write for one instruction per cycle
  producer must hold inst_valid_i / inst_i while stall_o is high
  stall_o is combinational: rob full, or a writer with no free register
  dispatch packet is registered, dest prf reads 0 when nothing is written
*/
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage #(
    parameter int PHYS_REGS = 64,
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         inst_valid_i,
    input  rename_pkg::inst_t            inst_i,
    output logic                         stall_o,
    rename_if.disp                       ren,
    rob_if.disp                          rob,
    output logic                         disp_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0] disp_rob_idx_o,
    output rename_pkg::fu_class_t        disp_fu_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_dest_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_src1_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_src2_prf_o,
    output logic                         disp_is_mem_o,
    output logic                         disp_is_store_o
);
    import rename_pkg::*;

    localparam int PW = $clog2(PHYS_REGS);

    fu_class_t     fu;
    logic          has_dest;
    logic          is_mem;
    logic          is_store;
    logic          wen;        // renames a real rd
    logic          accept;
    logic [PW-1:0] dest_prf;

    inst_decoder u_decoder (
        .inst_i     (inst_i),
        .fu_o       (fu),
        .has_dest_o (has_dest),
        .is_mem_o   (is_mem),
        .is_store_o (is_store)
    );

    assign wen      = has_dest && (inst_i.r.rd != '0);   // x0 never renamed
    assign stall_o  = rob.full || (inst_valid_i && wen && (ren.free_count == '0));
    assign accept   = inst_valid_i && !stall_o;
    assign dest_prf = wen ? ren.new_prf : '0;

    // ==================================================
    // rename lookups and strobes
    // ==================================================
    assign ren.src1_arch = inst_i.r.rs1;
    assign ren.src2_arch = inst_i.r.rs2;
    assign ren.dest_arch = wen ? inst_i.r.rd : '0;
    assign ren.alloc     = accept && wen;     // pop head + map write

    assign rob.wr      = accept;
    assign rob.arch    = ren.dest_arch;
    assign rob.wen     = wen;
    assign rob.new_prf = dest_prf;
    assign rob.old_prf = wen ? ren.old_prf : '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            disp_valid_o <= 1'b0;
        end else begin
            disp_valid_o <= accept;   // one cycle per accepted word
        end
    end

    // packet for the reservation station
    always_ff @(posedge clock) begin
        if (accept) begin
            disp_rob_idx_o  <= rob.tail_idx;
            disp_fu_o       <= fu;
            disp_dest_prf_o <= dest_prf;
            disp_src1_prf_o <= ren.src1_prf;
            disp_src2_prf_o <= ren.src2_prf;
            disp_is_mem_o   <= is_mem;
            disp_is_store_o <= is_store;
        end
    end

endmodule

`default_nettype wire

//--- rename_top.sv
/*
  rename / dispatch front, plain ports only
  one instruction in per cycle, held by the producer while stall_o is high
  commit_i retires the rob head, its old register returns to the free list
*/
`timescale 1ns/1ps
`default_nettype none

module rename_top #(
    parameter int ARCH_REGS = rename_pkg::ARCH_REGS,
    parameter int PHYS_REGS = rename_pkg::PHYS_REGS,
    parameter int ROB_DEPTH = rename_pkg::ROB_DEPTH
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         inst_valid_i,
    input  rename_pkg::inst_t            inst_i,
    output logic                         stall_o,
    output logic                         disp_valid_o,
    output logic [$clog2(ROB_DEPTH)-1:0] disp_rob_idx_o,
    output rename_pkg::fu_class_t        disp_fu_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_dest_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_src1_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] disp_src2_prf_o,
    output logic                         disp_is_mem_o,
    output logic                         disp_is_store_o,
    input  logic                         commit_i,
    output logic                         commit_valid_o,
    output rename_pkg::arch_idx_t        commit_arch_o,
    output logic [$clog2(PHYS_REGS)-1:0] commit_new_prf_o,
    output logic [$clog2(PHYS_REGS)-1:0] commit_old_prf_o
);
    logic                         release_valid;   // rob -> free list
    logic [$clog2(PHYS_REGS)-1:0] release_prf;

    rename_if #(.PHYS_REGS(PHYS_REGS)) ren_bus ();
    rob_if #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) rob_bus ();

    dispatch_stage #(.PHYS_REGS(PHYS_REGS), .ROB_DEPTH(ROB_DEPTH)) u_dispatch (
        .clock           (clock),
        .reset           (reset),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .stall_o         (stall_o),
        .ren             (ren_bus.disp),
        .rob             (rob_bus.disp),
        .disp_valid_o    (disp_valid_o),
        .disp_rob_idx_o  (disp_rob_idx_o),
        .disp_fu_o       (disp_fu_o),
        .disp_dest_prf_o (disp_dest_prf_o),
        .disp_src1_prf_o (disp_src1_prf_o),
        .disp_src2_prf_o (disp_src2_prf_o),
        .disp_is_mem_o   (disp_is_mem_o),
        .disp_is_store_o (disp_is_store_o)
    );

    map_table #(.PHYS_REGS(PHYS_REGS)) u_map (
        .clock (clock),
        .reset (reset),
        .ren   (ren_bus.tables)
    );

    free_list #(.PHYS_REGS(PHYS_REGS), .ARCH_REGS(ARCH_REGS)) u_free (
        .clock           (clock),
        .reset           (reset),
        .ren             (ren_bus.tables),
        .release_valid_i (release_valid),
        .release_prf_i   (release_prf)
    );

    reorder_buffer #(.ROB_DEPTH(ROB_DEPTH), .PHYS_REGS(PHYS_REGS)) u_rob (
        .clock            (clock),
        .reset            (reset),
        .rob              (rob_bus.buffer),
        .commit_i         (commit_i),
        .commit_valid_o   (commit_valid_o),
        .commit_arch_o    (commit_arch_o),
        .commit_new_prf_o (commit_new_prf_o),
        .commit_old_prf_o (commit_old_prf_o),
        .release_valid_o  (release_valid),
        .release_prf_o    (release_prf)
    );

endmodule

`default_nettype wire

//--- rename_sva.sv
/*
  concurrent checks on the dispatch stage, bound into every dispatch_stage
  free_empty_i and accept_i are formed in the bind from dispatch signals
*/
`timescale 1ns/1ps
`default_nettype none

module rename_sva (
    input logic clock,
    input logic reset,
    input logic stall_i,
    input logic alloc_i,
    input logic free_empty_i,
    input logic accept_i,
    input logic disp_valid_i
);
    // no pop while the producer is held
    alloc_not_stalled: assert property (@(posedge clock) disable iff (!reset)
        !(alloc_i && stall_i))
        else $error("alloc high while stall_o high");

    alloc_has_free: assert property (@(posedge clock) disable iff (!reset)
        !(alloc_i && free_empty_i))
        else $error("alloc with an empty free list");

    // packet one cycle after acceptance, and only then
    disp_follows_accept: assert property (@(posedge clock) disable iff (!reset)
        accept_i |=> disp_valid_i)
        else $error("disp_valid_o missing after accept");

    no_spurious_disp: assert property (@(posedge clock) disable iff (!reset)
        !accept_i |=> !disp_valid_i)
        else $error("disp_valid_o without accept");

endmodule

bind dispatch_stage rename_sva u_sva (
    .clock        (clock),
    .reset        (reset),
    .stall_i      (stall_o),
    .alloc_i      (ren.alloc),
    .free_empty_i (ren.free_count == '0),
    .accept_i     (inst_valid_i && !stall_o),
    .disp_valid_i (disp_valid_o)
);

`default_nettype wire

//--- tb_rename_top.sv
/*
  stands in for fetch and commit around rename_top
  runs with 40 physical registers so the free list empties before the rob fills
  reference model tracks map, free list fifo and rob queue at each falling edge
  inputs change 1 ns after the rising edge and outputs are sampled at the falling edge
*/
`timescale 1ns/1ps
`default_nettype none

module tb_rename_top;
    import rename_pkg::*;

    localparam int ARCH   = 32;
    localparam int PHYS   = 40;   // 8 free registers
    localparam int ROB    = 16;
    localparam int PW     = $clog2(PHYS);
    localparam int IW     = $clog2(ROB);
    localparam int N_RAND = 300;
    localparam int N_OPS  = N_RAND + 150;   // random ops plus directed and drain cycles

    typedef struct packed {
        logic [IW-1:0] rob_idx;
        fu_class_t     fu;
        logic [PW-1:0] dest;
        logic [PW-1:0] src1;
        logic [PW-1:0] src2;
        logic          is_mem;
        logic          is_store;
    } disp_rec_t;

    typedef struct packed {
        arch_idx_t     arch;
        logic [PW-1:0] new_prf;
        logic [PW-1:0] old_prf;
    } commit_rec_t;

    typedef struct packed {
        arch_idx_t     arch;
        logic [PW-1:0] new_prf;
        logic [PW-1:0] old_prf;
        logic          wen;
    } rob_ent_t;

    logic clock, reset, inst_valid_i, commit_i;
    inst_t inst_i;
    logic stall_o, disp_valid_o, disp_is_mem_o, disp_is_store_o, commit_valid_o;
    logic [IW-1:0] disp_rob_idx_o;
    fu_class_t disp_fu_o;
    logic [PW-1:0] disp_dest_prf_o, disp_src1_prf_o, disp_src2_prf_o;
    arch_idx_t commit_arch_o;
    logic [PW-1:0] commit_new_prf_o, commit_old_prf_o;

    // ==================================================
    // reference model state
    // ==================================================
    logic [PW-1:0] map_m [ARCH];
    logic [PW-1:0] free_q [$];
    rob_ent_t      rob_q [$];
    disp_rec_t     exp_disp_q [$];
    commit_rec_t   exp_commit_q [$];
    int            tail_n = 0;
    logic          rel1_v = 1'b0, rel2_v = 1'b0;   // release two edges behind commit
    logic [PW-1:0] rel1_p = '0, rel2_p = '0;
    logic [31:0]   lcg_state = 32'd51223;
    int disp_errs = 0, commit_errs = 0, stall_errs = 0, other_errs = 0;
    int stall_seen = 0;

    rename_top #(.ARCH_REGS(ARCH), .PHYS_REGS(PHYS), .ROB_DEPTH(ROB)) dut (
        .clock(clock), .reset(reset), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .stall_o(stall_o), .disp_valid_o(disp_valid_o), .disp_rob_idx_o(disp_rob_idx_o),
        .disp_fu_o(disp_fu_o), .disp_dest_prf_o(disp_dest_prf_o),
        .disp_src1_prf_o(disp_src1_prf_o), .disp_src2_prf_o(disp_src2_prf_o),
        .disp_is_mem_o(disp_is_mem_o), .disp_is_store_o(disp_is_store_o),
        .commit_i(commit_i), .commit_valid_o(commit_valid_o), .commit_arch_o(commit_arch_o),
        .commit_new_prf_o(commit_new_prf_o), .commit_old_prf_o(commit_old_prf_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic inst_t make_inst(input logic [6:0] op, input int rd, input int rs1,
                                        input int rs2, input logic f7b0);
        inst_t w;
        w          = '0;
        w.r.opcode = op;
        w.r.rd     = 5'(rd);
        w.r.rs1    = 5'(rs1);
        w.r.rs2    = 5'(rs2);
        w.r.funct7 = {6'b0, f7b0};
        return w;
    endfunction

    // opcode of the random word steered over the known set plus one unknown
    function automatic inst_t gen_inst();
        inst_t       w;
        logic [31:0] r;
        r = lcg_next();
        w = inst_t'(lcg_next());
        case (r[30:28])
            3'd0: w.r.opcode = OP_REG;
            3'd1: w.r.opcode = OP_IMM;
            3'd2: w.r.opcode = OP_LOAD;
            3'd3: w.r.opcode = OP_STORE;
            3'd4: w.r.opcode = OP_BRANCH;
            3'd5: w.r.opcode = OP_JAL;
            3'd6: w.r.opcode = OP_LUI;
            default: w.r.opcode = 7'b1111111;
        endcase
        return w;
    endfunction

    function automatic logic writes_rd(input inst_t w);
        logic [6:0] op;
        op = w.r.opcode;
        return (op == OP_REG || op == OP_IMM || op == OP_LOAD || op == OP_JAL ||
                op == OP_LUI) && (w.r.rd != 5'd0);
    endfunction

    // builds the expected packet and steps map, free list and rob queue
    function automatic disp_rec_t ref_dispatch(input inst_t w);
        disp_rec_t     e;
        logic          wen;
        logic [PW-1:0] old_p;
        logic [6:0]    op;
        op         = w.r.opcode;
        wen        = writes_rd(w);
        e.rob_idx  = IW'(tail_n);
        tail_n     = (tail_n + 1) % ROB;
        e.fu       = FU_ALU;
        e.is_mem   = (op == OP_LOAD) || (op == OP_STORE);
        e.is_store = (op == OP_STORE);
        if (op == OP_REG && w.r.funct7[0]) e.fu = FU_MULT;
        if (e.is_mem) e.fu = FU_MEM;
        if (op == OP_BRANCH || op == OP_JAL) e.fu = FU_BRANCH;
        e.src1 = map_m[w.r.rs1];
        e.src2 = map_m[w.r.rs2];
        e.dest = '0;
        old_p  = '0;
        if (wen) begin
            e.dest         = free_q.pop_front();
            old_p          = map_m[w.r.rd];
            map_m[w.r.rd]  = e.dest;
        end
        rob_q.push_back('{arch: wen ? w.r.rd : 5'd0, new_prf: e.dest, old_prf: old_p, wen: wen});
        return e;
    endfunction

    function automatic commit_rec_t ref_commit();
        rob_ent_t ent;
        ent = rob_q.pop_front();
        if (ent.wen) begin
            rel1_v = 1'b1;
            rel1_p = ent.old_prf;
        end
        return '{arch: ent.arch, new_prf: ent.new_prf, old_prf: ent.old_prf};
    endfunction

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_disp(input disp_rec_t exp, input disp_rec_t got);
        if (got !== exp) begin
            disp_errs++;
            $display("Fail %0t: dispatch exp idx=%0d fu=%0d d=%0d s1=%0d s2=%0d m=%b s=%b",
                     $time, exp.rob_idx, exp.fu, exp.dest, exp.src1, exp.src2, exp.is_mem,
                     exp.is_store);
            $display("    got idx=%0d fu=%0d d=%0d s1=%0d s2=%0d m=%b s=%b",
                     got.rob_idx, got.fu, got.dest, got.src1, got.src2, got.is_mem,
                     got.is_store);
        end
    endtask

    task automatic check_commit(input commit_rec_t exp, input commit_rec_t got);
        if (got !== exp) begin
            commit_errs++;
            $display("Fail %0t: commit exp x%0d new=%0d old=%0d, got x%0d new=%0d old=%0d",
                     $time, exp.arch, exp.new_prf, exp.old_prf, got.arch, got.new_prf,
                     got.old_prf);
        end
    endtask

    task automatic check_stall(input logic exp, input logic got);
        if (got !== exp) begin
            stall_errs++;
            $display("Fail %0t: stall_o exp %b got %b", $time, exp, got);
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // model step in the same order as the dut edge
    always @(negedge clock) begin
        logic can_commit;
        if (reset) begin
            if (rel2_v) free_q.push_back(rel2_p);
            rel2_v     = rel1_v;
            rel2_p     = rel1_p;
            rel1_v     = 1'b0;
            can_commit = (rob_q.size() != 0);   // empty rob ignores commit
            check_stall((rob_q.size() == ROB) ||
                        (inst_valid_i && writes_rd(inst_i) && free_q.size() == 0), stall_o);
            if (inst_valid_i && !stall_o) exp_disp_q.push_back(ref_dispatch(inst_i));
            if (commit_i && can_commit) exp_commit_q.push_back(ref_commit());
        end
    end

    // output compare
    always @(negedge clock) begin
        if (reset && disp_valid_o) begin
            if (exp_disp_q.size() == 0) begin
                other_errs++;
                $display("dispatch output appeared with no accepted instruction at %0t", $time);
            end else begin
                check_disp(exp_disp_q.pop_front(), '{rob_idx: disp_rob_idx_o, fu: disp_fu_o,
                           dest: disp_dest_prf_o, src1: disp_src1_prf_o,
                           src2: disp_src2_prf_o, is_mem: disp_is_mem_o,
                           is_store: disp_is_store_o});
            end
        end
        if (reset && commit_valid_o) begin
            if (exp_commit_q.size() == 0) begin
                other_errs++;
                $display("commit output appeared with nothing to retire at %0t", $time);
            end else begin
                check_commit(exp_commit_q.pop_front(), '{arch: commit_arch_o,
                             new_prf: commit_new_prf_o, old_prf: commit_old_prf_o});
            end
        end
    end

    initial begin
        #(N_OPS * 40);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    task automatic drive_cycle(input logic v, input inst_t w, input logic c, output logic acc);
        inst_valid_i = v;
        inst_i       = w;
        commit_i     = c;
        @(negedge clock);
        acc = v && !stall_o;
        @(posedge clock);
        #1;
    endtask

    // mode 0 no commits, 1 random commits, 2 one commit after 3 stalled cycles
    task automatic send(input inst_t w, input int mode);
        logic        acc;
        logic        c;
        logic [31:0] r;
        int          tries;
        acc   = 1'b0;
        tries = 0;
        while (!acc) begin
            r = lcg_next();
            c = ((mode == 1) && r[20]) || ((mode == 2) && (tries == 3));
            drive_cycle(1'b1, w, c, acc);
            if (!acc) stall_seen++;
            tries++;
        end
        inst_valid_i = 1'b0;
        commit_i     = 1'b0;
    endtask

    task automatic idle(input int n, input logic c);
        logic acc;
        repeat (n) drive_cycle(1'b0, '0, c, acc);
        commit_i = 1'b0;
    endtask

    task automatic drain();
        idle(ROB + 4, 1'b1);   // extra strobes land on an empty rob
        idle(3, 1'b0);
    endtask

    initial begin
        reset        = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        commit_i     = 1'b0;
        for (int i = 0; i < ARCH; i++) map_m[i] = PW'(i);
        for (int i = ARCH; i < PHYS; i++) free_q.push_back(PW'(i));
        repeat (8) @(posedge clock);
        #1 reset = 1'b1;

        // dependent pair, x0 writer, every format
        send(make_inst(OP_REG, 5, 1, 2, 1'b0), 0);
        send(make_inst(OP_REG, 6, 5, 5, 1'b1), 0);
        send(make_inst(OP_IMM, 0, 5, 6, 1'b0), 0);
        send(make_inst(OP_STORE, 9, 6, 5, 1'b0), 0);
        send(make_inst(OP_BRANCH, 3, 5, 6, 1'b0), 0);
        send(make_inst(OP_LOAD, 7, 6, 0, 1'b0), 0);
        send(make_inst(OP_JAL, 1, 0, 0, 1'b0), 0);
        send(make_inst(OP_LUI, 2, 7, 1, 1'b0), 0);
        drain();

        // free list exhaustion
        for (int i = 1; i <= PHYS - ARCH; i++) send(make_inst(OP_IMM, i, i, 0, 1'b0), 0);
        stall_seen = 0;
        send(make_inst(OP_REG, 20, 1, 2, 1'b0), 2);
        if (stall_seen == 0) begin
            other_errs++;
            $display("writer was not held back with the free list empty");
        end
        drain();

        // rob full with stores only
        for (int i = 0; i < ROB; i++) send(make_inst(OP_STORE, 0, i, i + 1, 1'b0), 0);
        stall_seen = 0;
        send(make_inst(OP_STORE, 0, 3, 4, 1'b0), 2);
        if (stall_seen == 0) begin
            other_errs++;
            $display("instruction was not held back with the rob full");
        end
        drain();

        repeat (N_RAND) send(gen_inst(), 1);
        drain();
        idle(4, 1'b0);
        if (exp_disp_q.size() != 0 || exp_commit_q.size() != 0) begin
            other_errs++;
            $display("expected outputs still pending at the end of the run");
        end
        $display("errors: dispatch=%0d commit=%0d stall=%0d other=%0d",
                 disp_errs, commit_errs, stall_errs, other_errs);
        if (disp_errs + commit_errs + stall_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rename_pkg.sv
rename_ifs.sv
inst_decoder.sv
free_list.sv
map_table.sv
reorder_buffer.sv
dispatch_stage.sv
rename_top.sv
rename_sva.sv
tb_rename_top.sv

//--- run.sh
#!/bin/sh
# build and run the rename testbench with Verilator
# exit status 0 on pass, 1 on any failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_rename_top \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
STATUS=$?
cat "$LOG"
if [ $STATUS -ne 0 ]; then
    echo "simulation exited with status $STATUS"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST OK" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
